// File: common/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// fetch front end sizing
////////////////////////////////////////////////////////////////////////////

// instructions delivered per fetch bundle
`define FETCH_WIDTH 4

// instruction memory word address width
// 8 bits gives 256 words
`define IMEM_AW 8

`endif

// File: common/isa_pkg.sv
package isa_pkg;

   // one machine word, used for both addresses and instructions
   typedef logic [15:0] word_t;

   // jump opcode lives in the top nibble
   localparam logic [3:0] OPC_JUMP = 4'hf;
   localparam int OPC_HI = 15;
   localparam int OPC_LO = 12;
   // bit 0 picks immediate (clear) or base (set)
   localparam int KIND_BIT = 0;

   // immediate jump offset field
   localparam int IMM_HI = 11;
   localparam int IMM_LO = 2;
   localparam int IMM_W  = IMM_HI - IMM_LO + 1;

   // base jump register index and offset fields
   localparam int BREG_HI = 11;
   localparam int BREG_LO = 8;
   localparam int BOFF_HI = 7;
   localparam int BOFF_LO = 2;
   localparam int BOFF_W  = BOFF_HI - BOFF_LO + 1;

   typedef enum logic [1:0] {
      JK_NONE,
      JK_IMM,
      JK_BASE
   } jump_kind_e;

   // decode kind of one slot
   function automatic jump_kind_e jump_kind(word_t w);
      jump_kind_e k;
      if (w[OPC_HI:OPC_LO] != OPC_JUMP) begin
         k = JK_NONE;
      end else begin
         k = w[KIND_BIT] ? JK_BASE : JK_IMM;
      end
      return k;
   endfunction

   // sign-extended immediate offset
   function automatic word_t imm_off(word_t w);
      return {{($bits(word_t) - IMM_W){w[IMM_HI]}}, w[IMM_HI:IMM_LO]};
   endfunction

   // sign-extended base offset
   function automatic word_t base_off(word_t w);
      return {{($bits(word_t) - BOFF_W){w[BOFF_HI]}}, w[BOFF_HI:BOFF_LO]};
   endfunction

   // register file index holding the jump base
   function automatic logic [3:0] base_reg(word_t w);
      return w[BREG_HI:BREG_LO];
   endfunction

endpackage

// File: common/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // fetch side types
   ////////////////////////////////////////////////////////////////////////////

   // position of an instruction inside a bundle
   typedef logic [$clog2(`FETCH_WIDTH)-1:0] slot_t;

   // one fetch bundle, slot 0 at the fetch address
   typedef isa_pkg::word_t [`FETCH_WIDTH-1:0] bundle_t;

   // jump handler FSM
   // run scans bundles, wait_base holds fetch until the base value arrives
   typedef enum logic {
      JH_RUN,
      JH_WAIT_BASE
   } jh_state_e;

endpackage

// File: common/fetch_bundle_if.sv
// fetch address out to memory and the bundle coming back
// no handshake, instr follows pc combinationally
interface fetch_bundle_if ();

   isa_pkg::word_t     pc;
   fetch_pkg::bundle_t instr;

   // pc generator side
   modport fetch (
      output pc
   );

   // instruction memory side
   modport mem (
      input  pc,
      output instr
   );

   // jump handler only looks at both
   modport scan (
      input pc,
      input instr
   );

endinterface

// File: common/redirect_if.sv
// redirect request from jump handler to pc generator
interface redirect_if ();

   // jump_sel qualifies jump_addr in the same cycle
   logic           jump_sel;
   isa_pkg::word_t jump_addr;
   // hold pc while a base jump waits
   logic           stall;

   // jump handler side
   modport src (
      output jump_sel,
      output jump_addr,
      output stall
   );

   // pc generator side
   modport dst (
      input jump_sel,
      input jump_addr,
      input stall
   );

endinterface

// File: fetch/pc_gen.sv
`include "fetch_defines.svh"

module pc_gen (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           mispredict,
   input  isa_pkg::word_t mispredict_pc,
   redirect_if.dst        redir,
   fetch_bundle_if.fetch  bundle
);

   isa_pkg::word_t pc_q;
   isa_pkg::word_t pc_d;

   ////////////////////////////////////////////////////////////////////////////
   // next fetch address
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      // back end restart beats everything
      if (mispredict) begin
         pc_d = mispredict_pc;
      // taken jump, immediate or resolved base
      end else if (redir.jump_sel) begin
         pc_d = redir.jump_addr;
      // base jump outstanding
      end else if (redir.stall) begin
         pc_d = pc_q;
      end else begin
         // straight line, one full bundle ahead
         pc_d = pc_q + isa_pkg::word_t'(`FETCH_WIDTH);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_q <= '0;
      end else begin
         pc_q <= pc_d;
      end
   end

   // current fetch address to memory and handler
   assign bundle.pc = pc_q;

endmodule

// File: fetch/jump_handler.sv
`include "fetch_defines.svh"

module jump_handler (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               mispredict,
   input  logic               base_rdy,
   input  isa_pkg::word_t     base_value,
   fetch_bundle_if.scan       bundle,
   redirect_if.src            redir,
   output fetch_pkg::bundle_t slots,
   output logic               base_req,
   output logic [3:0]         base_reg
);

   fetch_pkg::jh_state_e state_q;
   // base value captured, redirect goes out next cycle
   logic                 pending_q;
   // sign-extended base offset of the waiting jump
   isa_pkg::word_t       boff_q;
   isa_pkg::word_t       bval_q;

   // first jump in the bundle
   fetch_pkg::slot_t     first_idx;
   isa_pkg::jump_kind_e  first_kind;
   isa_pkg::word_t       first_word;
   isa_pkg::word_t       imm_target;

   ////////////////////////////////////////////////////////////////////////////
   // bundle scan
   ////////////////////////////////////////////////////////////////////////////

   // lowest slot wins
   always_comb begin
      isa_pkg::jump_kind_e k;
      first_idx  = '0;
      first_kind = isa_pkg::JK_NONE;
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
         k = isa_pkg::jump_kind(bundle.instr[i]);
         if (first_kind == isa_pkg::JK_NONE && k != isa_pkg::JK_NONE) begin
            first_idx  = fetch_pkg::slot_t'(i);
            first_kind = k;
         end
      end
   end

   assign first_word = bundle.instr[first_idx];

   // target relative to the jump's own address plus one
   assign imm_target = bundle.pc + isa_pkg::word_t'(first_idx) + isa_pkg::word_t'(1)
                     + isa_pkg::imm_off(first_word);

   ////////////////////////////////////////////////////////////////////////////
   // redirect, stall and base request
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      redir.jump_sel  = 1'b0;
      redir.jump_addr = '0;
      redir.stall     = 1'b0;
      base_req        = 1'b0;
      base_reg        = '0;
      if (state_q == fetch_pkg::JH_RUN) begin
         if (!mispredict && first_kind == isa_pkg::JK_IMM) begin
            redir.jump_sel  = 1'b1;
            redir.jump_addr = imm_target;
         end
         // one cycle request, state moves on at the edge
         if (!mispredict && first_kind == isa_pkg::JK_BASE) begin
            base_req = 1'b1;
            base_reg = isa_pkg::base_reg(first_word);
         end
      end else if (pending_q) begin
         // base resolved, release fetch at the new address
         redir.jump_sel  = !mispredict;
         redir.jump_addr = bval_q + boff_q;
      end else begin
         redir.stall = 1'b1;
      end
   end

   // slots past a taken jump never reach decode
   // nothing passes while waiting or on mispredict
   always_comb begin
      logic keep;
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
         keep = state_q == fetch_pkg::JH_RUN && !mispredict
              && (first_kind == isa_pkg::JK_NONE || fetch_pkg::slot_t'(i) <= first_idx);
         slots[i] = keep ? bundle.instr[i] : '0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q   <= fetch_pkg::JH_RUN;
         pending_q <= 1'b0;
         boff_q    <= '0;
      end else if (mispredict) begin
         // drop any outstanding base jump
         state_q   <= fetch_pkg::JH_RUN;
         pending_q <= 1'b0;
         boff_q    <= '0;
      end else begin
         case (state_q)
            fetch_pkg::JH_RUN: begin
               if (first_kind == isa_pkg::JK_BASE) begin
                  state_q <= fetch_pkg::JH_WAIT_BASE;
                  boff_q  <= isa_pkg::base_off(first_word);
               end
            end
            fetch_pkg::JH_WAIT_BASE: begin
               if (pending_q) begin
                  state_q   <= fetch_pkg::JH_RUN;
                  pending_q <= 1'b0;
               end else if (base_rdy) begin
                  pending_q <= 1'b1;
               end
            end
            default: state_q <= fetch_pkg::JH_RUN;
         endcase
      end
   end

   // base value from the register file
   always_ff @(posedge clk) begin
      if (state_q == fetch_pkg::JH_WAIT_BASE && !pending_q && base_rdy) begin
         bval_q <= base_value;
      end
   end

endmodule

// File: src/inst_mem.sv
`include "fetch_defines.svh"

module inst_mem (
   input  logic                clk,
   input  logic                we,
   input  logic [`IMEM_AW-1:0] waddr,
   input  isa_pkg::word_t      wdata,
   fetch_bundle_if.mem         bundle
);

   localparam int DEPTH = 1 << `IMEM_AW;

   isa_pkg::word_t      mem [DEPTH];
   logic [`IMEM_AW-1:0] base_addr;
   fetch_pkg::bundle_t  rd_words;

   // load port, takes effect at the edge
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // upper pc bits fall away
   assign base_addr = bundle.pc[`IMEM_AW-1:0];

   // four consecutive words
   // address arithmetic wraps at the top of memory
   always_comb begin
      logic [`IMEM_AW-1:0] a;
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
         a = base_addr + `IMEM_AW'(i);
         rd_words[i] = mem[a];
      end
   end

   assign bundle.instr = rd_words;

endmodule

// File: src/fetch_top.sv
`include "fetch_defines.svh"

module fetch_top (
   input  logic                clk,
   input  logic                rst_n,
   // back end restart
   input  logic                mispredict,
   input  isa_pkg::word_t      mispredict_pc,
   // base value from the register file
   input  logic                base_rdy,
   input  isa_pkg::word_t      base_value,
   // instruction memory load port
   input  logic                imem_we,
   input  logic [`IMEM_AW-1:0] imem_waddr,
   input  isa_pkg::word_t      imem_wdata,
   // issue to decode
   output isa_pkg::word_t      fetch_pc,
   output isa_pkg::word_t      slot0,
   output isa_pkg::word_t      slot1,
   output isa_pkg::word_t      slot2,
   output isa_pkg::word_t      slot3,
   output logic                stall,
   // base request to the register file
   output logic                base_req,
   output logic [3:0]          base_reg
);

   fetch_bundle_if bundle_if ();
   redirect_if     redir_if ();

   fetch_pkg::bundle_t slots;

   ////////////////////////////////////////////////////////////////////////////
   // fetch blocks
   ////////////////////////////////////////////////////////////////////////////

   pc_gen i_pc_gen (
      .clk           (clk),
      .rst_n         (rst_n),
      .mispredict    (mispredict),
      .mispredict_pc (mispredict_pc),
      .redir         (redir_if.dst),
      .bundle        (bundle_if.fetch)
   );

   inst_mem i_inst_mem (
      .clk    (clk),
      .we     (imem_we),
      .waddr  (imem_waddr),
      .wdata  (imem_wdata),
      .bundle (bundle_if.mem)
   );

   jump_handler i_jump_handler (
      .clk        (clk),
      .rst_n      (rst_n),
      .mispredict (mispredict),
      .base_rdy   (base_rdy),
      .base_value (base_value),
      .bundle     (bundle_if.scan),
      .redir      (redir_if.src),
      .slots      (slots),
      .base_req   (base_req),
      .base_reg   (base_reg)
   );

   // flatten for decode
   assign fetch_pc = bundle_if.pc;
   assign slot0    = slots[0];
   assign slot1    = slots[1];
   assign slot2    = slots[2];
   assign slot3    = slots[3];
   assign stall    = redir_if.stall;

endmodule

// File: dv/fetch_assertions.sv
// protocol checks on the jump handler outputs
// bound into every jump_handler instance
module fetch_assertions (
   input logic               clk,
   input logic               rst_n,
   input logic               mispredict,
   input logic               stall,
   input logic               jump_sel,
   input logic               base_req,
   input fetch_pkg::bundle_t slots
);

   // bumped by each failing assertion, read from the testbench
   int unsigned fail_cnt = 0;

   ////////////////////////////////////////////////////////////////////////////
   // redirect and stall
   ////////////////////////////////////////////////////////////////////////////

   // a redirect never coincides with a hold
   a_sel_stall: assert property (@(posedge clk) disable iff (!rst_n)
      !(stall && jump_sel))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("jump_sel and stall are high in the same cycle");
      end

   // back end restart overrides any redirect
   a_mis_no_sel: assert property (@(posedge clk) disable iff (!rst_n)
      mispredict |-> !jump_sel)
      else begin
         fail_cnt = fail_cnt + 1;
         $error("jump_sel is high during a mispredict");
      end

   ////////////////////////////////////////////////////////////////////////////
   // base request and slot squashing
   ////////////////////////////////////////////////////////////////////////////

   // one cycle strobe, FSM leaves run at the edge
   a_req_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      base_req |=> !base_req)
      else begin
         fail_cnt = fail_cnt + 1;
         $error("base_req stays high for more than one cycle");
      end

   // nothing reaches decode while waiting for the base
   a_stall_zero: assert property (@(posedge clk) disable iff (!rst_n)
      stall |-> (slots == '0))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("slots are not zero while stall is high");
      end

endmodule

// File: dv/fetch_tb.sv
`include "fetch_defines.svh"

module fetch_tb;

   localparam int RST_CYCLES  = 16;
   localparam int LOAD_CYCLES = 1 << `IMEM_AW;
   localparam int RUN_CYCLES  = 2000;
   localparam int DEPTH       = 1 << `IMEM_AW;

   // expected DUT outputs for one cycle
   typedef struct packed {
      logic [15:0]      pc;
      logic [3:0][15:0] slots;
      logic             stall;
      logic             base_req;
      logic [3:0]       base_reg;
   } expect_t;

   logic                clk = 1'b0;
   logic                rst_n;
   logic                mispredict;
   logic [15:0]         mispredict_pc;
   logic                base_rdy;
   logic [15:0]         base_value;
   logic                imem_we;
   logic [`IMEM_AW-1:0] imem_waddr;
   logic [15:0]         imem_wdata;
   logic [15:0]         fetch_pc;
   logic [15:0]         slot0;
   logic [15:0]         slot1;
   logic [15:0]         slot2;
   logic [15:0]         slot3;
   logic                stall;
   logic                base_req;
   logic [3:0]          base_reg;

   // program image, also what the reference model fetches from
   logic [15:0] prog [DEPTH];
   logic [31:0] lcg_state = 32'hcd67617e;

   // reference model state, reset values
   logic [15:0] m_pc   = '0;
   logic        m_wait = 1'b0;
   logic        m_pend = 1'b0;
   logic [15:0] m_boff = '0;
   logic [15:0] m_bval = '0;

   // register file model for base jumps
   logic        waiting = 1'b0;
   int          wait_cnt = 0;

   fetch_top i_dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .mispredict    (mispredict),
      .mispredict_pc (mispredict_pc),
      .base_rdy      (base_rdy),
      .base_value    (base_value),
      .imem_we       (imem_we),
      .imem_waddr    (imem_waddr),
      .imem_wdata    (imem_wdata),
      .fetch_pc      (fetch_pc),
      .slot0         (slot0),
      .slot1         (slot1),
      .slot2         (slot2),
      .slot3         (slot3),
      .stall         (stall),
      .base_req      (base_req),
      .base_reg      (base_reg)
   );

   bind jump_handler fetch_assertions i_fetch_assertions (
      .clk        (clk),
      .rst_n      (rst_n),
      .mispredict (mispredict),
      .stall      (redir.stall),
      .jump_sel   (redir.jump_sel),
      .base_req   (base_req),
      .slots      (slots)
   );

   always #5 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
      if (exp !== act) begin
         $display("[ERROR] %s expected 0x%04h got 0x%04h at %0t", name, exp, act, $time);
         $display("Test FAILED");
         $fatal(1, "output mismatch on %s", name);
      end
   endtask

   // random program, roughly one word in eight of each jump kind
   task automatic gen_program();
      logic [31:0] r;
      logic [15:0] w;
      for (int a = 0; a < DEPTH; a++) begin
         r = lcg_next();
         case (r[31:29])
            // immediate, offset -16..15
            3'd0: w = {4'hf, {5{r[20]}}, r[20:16], r[1], 1'b0};
            // base, any register and 6 bit offset
            3'd1: w = {4'hf, r[11:8], r[21:16], r[1], 1'b1};
            default: begin
               w = r[15:0];
               if (w[15:12] == 4'hf) begin
                  w[15] = 1'b0;
               end
            end
         endcase
         prog[a] = w;
      end
   endtask

   task automatic load_memory();
      for (int a = 0; a < DEPTH; a++) begin
         imem_we    = 1'b1;
         imem_waddr = `IMEM_AW'(a);
         imem_wdata = prog[a];
         next_cycle();
      end
      imem_we = 1'b0;
   endtask

   // random mispredicts, base value after a random wait of 0 to 6 cycles
   task automatic drive_inputs();
      logic [31:0] r;
      logic [31:0] v;
      r = lcg_next();
      v = lcg_next();
      mispredict    = (r[31:27] == 5'd0);
      mispredict_pc = r[15:0];
      base_value    = v[31:16];
      if (stall) begin
         if (!waiting) begin
            waiting  = 1'b1;
            wait_cnt = r[26:24] % 7;
         end
         if (wait_cnt == 0) begin
            base_rdy = 1'b1;
         end else begin
            base_rdy = 1'b0;
            wait_cnt = wait_cnt - 1;
         end
      end else begin
         waiting  = 1'b0;
         base_rdy = 1'b0;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   // outputs of the current cycle, then advance the model by one edge
   function automatic expect_t ref_step(input logic mis, input logic [15:0] mis_pc,
                                        input logic rdy, input logic [15:0] bv);
      expect_t     e;
      logic [15:0] w [4];
      logic [7:0]  a;
      int          first;
      logic        jsel;
      logic [15:0] jaddr;
      e     = '0;
      e.pc  = m_pc;
      jsel  = 1'b0;
      jaddr = '0;
      first = -1;
      // memory wraps, upper pc bits unused
      for (int i = 0; i < 4; i++) begin
         a    = m_pc[7:0] + 8'(i);
         w[i] = prog[a];
         if (first < 0 && w[i][15:12] == 4'hf) begin
            first = i;
         end
      end
      if (!m_wait) begin
         if (!mis) begin
            for (int i = 0; i < 4; i++) begin
               if (first < 0 || i <= first) begin
                  e.slots[i] = w[i];
               end
            end
            // immediate target from the jump's own address plus one
            if (first >= 0 && !w[first][0]) begin
               jsel  = 1'b1;
               jaddr = m_pc + 16'(first) + 16'd1 + {{6{w[first][11]}}, w[first][11:2]};
            end
            if (first >= 0 && w[first][0]) begin
               e.base_req = 1'b1;
               e.base_reg = w[first][11:8];
            end
         end
      end else if (m_pend) begin
         jsel  = !mis;
         jaddr = m_bval + m_boff;
      end else begin
         e.stall = 1'b1;
      end
      // state at the next edge
      if (mis) begin
         m_pc   = mis_pc;
         m_wait = 1'b0;
         m_pend = 1'b0;
         m_boff = '0;
      end else begin
         if (jsel) begin
            m_pc = jaddr;
         end else if (!e.stall) begin
            m_pc = m_pc + 16'd4;
         end
         if (!m_wait) begin
            if (e.base_req) begin
               m_wait = 1'b1;
               m_boff = {{10{w[first][7]}}, w[first][7:2]};
            end
         end else if (m_pend) begin
            m_wait = 1'b0;
            m_pend = 1'b0;
         end else if (rdy) begin
            m_pend = 1'b1;
            m_bval = bv;
         end
      end
      return e;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // stimulus, checker, watchdog
   ////////////////////////////////////////////////////////////////////////////

   // mispredict held through reset and load keeps outputs defined
   // restart address away from zero so only the reset can hold pc at 0
   initial begin
      rst_n         = 1'b0;
      mispredict    = 1'b1;
      mispredict_pc = 16'h0a5c;
      base_rdy      = 1'b0;
      base_value    = '0;
      imem_we       = 1'b0;
      imem_waddr    = '0;
      imem_wdata    = '0;
      gen_program();
      repeat (RST_CYCLES) next_cycle();
      rst_n = 1'b1;
      load_memory();
      mispredict = 1'b0;
      repeat (RUN_CYCLES) begin
         drive_inputs();
         next_cycle();
      end
      $display("Test OK");
      $finish;
   end

   // compare just before the next edge
   initial begin
      expect_t e;
      forever begin
         @(posedge clk);
         #8;
         e = ref_step(mispredict, mispredict_pc, base_rdy, base_value);
         check_val("fetch_pc", e.pc, fetch_pc);
         check_val("slot0", e.slots[0], slot0);
         check_val("slot1", e.slots[1], slot1);
         check_val("slot2", e.slots[2], slot2);
         check_val("slot3", e.slots[3], slot3);
         check_val("stall", 16'(e.stall), 16'(stall));
         check_val("base_req", 16'(e.base_req), 16'(base_req));
         check_val("base_reg", 16'(e.base_reg), 16'(base_reg));
         check_val("assertion_failures", 16'd0,
                   16'(i_dut.i_jump_handler.i_fetch_assertions.fail_cnt));
         // model follows the DUT's asynchronous reset
         if (!rst_n) begin
            m_pc   = '0;
            m_wait = 1'b0;
            m_pend = 1'b0;
            m_boff = '0;
         end
      end
   end

   initial begin
      #((RST_CYCLES + LOAD_CYCLES + RUN_CYCLES + 100) * 10);
      $display("watchdog expired before the test sequence finished");
      $display("Test FAILED");
      $fatal(1, "timeout");
   end

endmodule

// File: src.f
+incdir+common
common/isa_pkg.sv
common/fetch_pkg.sv
common/fetch_bundle_if.sv
common/redirect_if.sv
fetch/pc_gen.sv
fetch/jump_handler.sv
src/inst_mem.sv
src/fetch_top.sv
dv/fetch_assertions.sv
dv/fetch_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module fetch_tb -o fetch_sim
	./obj_dir/fetch_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "Test OK" $(LOG); then \
		echo "simulation ended without passing"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
